//--- common/audioBusPkg.sv
/*
 * Audio memory bus package
 * Widths of the external memory read bus and of the word
 * split that the DMA performs before the audio FIFO
 */
package audioBusPkg;

	//--------------------------------------------------------------------
	// External memory read bus
	//--------------------------------------------------------------------
	// Data word returned by memRdData
	localparam int memDataWidth = 16;

	//--------------------------------------------------------------------
	// DMA word split
	//--------------------------------------------------------------------
	// Samples per memory word, low byte goes out first
	localparam int bytesPerWord = 2;

endpackage

//--- common/audioSynthPkg.sv
/*
 * Audio synthesizer package
 * Sample width, FIFO byte decoding, note tuning table and the
 * constants shared by the tone synthesizer and its wave ROM
 */
package audioSynthPkg;

	//--------------------------------------------------------------------
	// Sample format
	//--------------------------------------------------------------------
	// PWM resolution and FIFO width
	localparam int sampleWidth = 8;

	// Mid-scale duty, used for no data and for a note off
	localparam logic [sampleWidth-1:0] silenceLevel = sampleWidth'(128);

	// Note code carried in tone mode
	typedef struct packed {
		logic       noteOn;
		logic [2:0] octave;
		logic [3:0] semitone;
	} noteCodeT;

	// One FIFO byte, a raw PCM duty or a note code
	typedef union packed {
		logic [sampleWidth-1:0] pcm;
		noteCodeT               note;
	} audioByteU;

	//--------------------------------------------------------------------
	// Tone generation
	//--------------------------------------------------------------------
	// Phase accumulator width
	localparam int phaseWidth = 16;

	// Phase steps for octave 7, C up to B
	// Lower octaves shift these right by 7 minus octave
	localparam logic [phaseWidth-1:0] semitoneStep [12] = '{
		16'd8192,  16'd8679,  16'd9195,  16'd9742,
		16'd10321, 16'd10935, 16'd11585, 16'd12274,
		16'd13004, 16'd13777, 16'd14596, 16'd15464
	};

	// Quarter-wave sine magnitudes, 64 hex entries
	localparam sineFile = "audioSynth/quarterSine.hex";

endpackage

//--- audioDma/audioDma.sv
/*
 * Audio DMA
 * Reads dmaLen words from memory starting at dmaAdrs, one request
 * at a time, and hands each word to the FIFO as bytes, low first
 */
`timescale 1ns/1ps

module audioDma
	import audioBusPkg::*, audioSynthPkg::*;
#(
	parameter int memAdrsWidth = 19
)(
	input  logic                    sClk,
	input  logic                    rstN,
	input  logic                    dmaEn,
	input  logic [memAdrsWidth-1:0] dmaAdrs,
	input  logic [memAdrsWidth-1:0] dmaLen,
	output logic                    dmaBusy,
	output logic [memAdrsWidth-1:0] memAdrs,
	output logic                    memReq,
	input  logic                    memRdy,
	input  logic                    memRdValid,
	input  logic [memDataWidth-1:0] memRdData,
	output logic                    wrValid,
	output logic [sampleWidth-1:0]  wrData,
	input  logic                    wrReady
);

	// Byte select counter width
	localparam int selWidth = (bytesPerWord > 1) ? $clog2(bytesPerWord) : 1;

	// FSM encoding
	localparam logic [1:0] stIdle = 2'd0;
	localparam logic [1:0] stReq  = 2'd1;
	localparam logic [1:0] stWait = 2'd2;
	localparam logic [1:0] stSend = 2'd3;

	logic [1:0]              state;
	logic [memAdrsWidth-1:0] curAdrs;
	logic [memAdrsWidth-1:0] wordsLeft;
	logic [memDataWidth-1:0] wordReg;
	logic [selWidth-1:0]     byteSel;
	logic                    startDma;
	logic                    reqAccept;
	logic                    byteAccept;
	logic                    lastByte;

	assign startDma   = (state == stIdle) & dmaEn;
	assign reqAccept  = memReq & memRdy;
	assign byteAccept = wrValid & wrReady;
	assign lastByte   = (byteSel == selWidth'(bytesPerWord - 1));

	//--------------------------------------------------------------------
	// Control FSM
	//--------------------------------------------------------------------
	always_ff @(posedge sClk)
	begin
		if (!rstN)
		begin
			state   <= stIdle;
			byteSel <= '0;
		end
		else
		begin
			case (state)
				stIdle:
					if (dmaEn)
						state <= stReq;
				// Address held until memRdy
				stReq:
					if (memRdy)
						state <= stWait;
				stWait:
					if (memRdValid)
						state <= stSend;
				default:
					if (byteAccept)
					begin
						if (lastByte)
						begin
							byteSel <= '0;
							// Count already taken at request accept
							state   <= (wordsLeft == '0) ? stIdle : stReq;
						end
						else
							byteSel <= byteSel + 1'b1;
					end
			endcase
		end
	end

	//--------------------------------------------------------------------
	// Address, word count and returned word
	//--------------------------------------------------------------------
	always_ff @(posedge sClk)
	begin
		if (startDma)
		begin
			curAdrs   <= dmaAdrs;
			wordsLeft <= dmaLen;
		end
		else if (reqAccept)
		begin
			curAdrs   <= curAdrs + 1'b1;
			wordsLeft <= wordsLeft - 1'b1;
		end
		// Single outstanding read
		if ((state == stWait) && memRdValid)
			wordReg <= memRdData;
	end

	// Outputs straight from state
	assign dmaBusy = (state != stIdle);
	assign memReq  = (state == stReq);
	assign memAdrs = curAdrs;
	assign wrValid = (state == stSend);
	assign wrData  = wordReg[byteSel*sampleWidth +: sampleWidth];

endmodule

//--- audioFifo/audioDualClkFifo.sv
/*
 * Audio dual-clock FIFO
 * Moves sample bytes from sClk to audioClk with gray-coded
 * pointers passed through two-flop synchronizers
 */
`timescale 1ns/1ps

module audioDualClkFifo
	import audioSynthPkg::*;
#(
	parameter int fifoDepth = 32
)(
	input  logic                   sClk,
	input  logic                   audioClk,
	input  logic                   rstN,
	// Write side, sClk
	input  logic                   wrValid,
	input  logic [sampleWidth-1:0] wrData,
	output logic                   wrReady,
	// Read side, audioClk
	input  logic                   rdPop,
	output audioByteU              rdData,
	output logic                   rdEmpty
);

	localparam int adrsWidth = $clog2(fifoDepth);

	logic [sampleWidth-1:0] fifoMem [fifoDepth];

	// Extra pointer bit tells full from empty
	logic [adrsWidth:0] wrBin, wrBinNext, wrGray, rdGraySync1, rdGraySync2;
	logic [adrsWidth:0] rdBin, rdBinNext, rdGray, wrGraySync1, wrGraySync2;
	logic               wrPush, wrFull, rdTake, rdRstN;
	logic [1:0]         rdRstSync;

	function automatic logic [adrsWidth:0] toGray(input logic [adrsWidth:0] bin);
		return bin ^ (bin >> 1);
	endfunction

	//--------------------------------------------------------------------
	// Write side
	//--------------------------------------------------------------------
	assign wrPush    = wrValid & wrReady;
	assign wrBinNext = wrBin + (adrsWidth+1)'(wrPush);
	// Full when the top two gray bits differ and the rest match
	assign wrFull    = (wrGray == {~rdGraySync2[adrsWidth -: 2], rdGraySync2[adrsWidth-2:0]});
	assign wrReady   = ~wrFull;

	always_ff @(posedge sClk)
	begin
		if (!rstN)
		begin
			wrBin       <= '0;
			wrGray      <= '0;
			rdGraySync1 <= '0;
			rdGraySync2 <= '0;
		end
		else
		begin
			wrBin       <= wrBinNext;
			wrGray      <= toGray(wrBinNext);
			rdGraySync1 <= rdGray;
			rdGraySync2 <= rdGraySync1;
		end
	end

	always_ff @(posedge sClk)
	begin
		if (wrPush)
			fifoMem[wrBin[adrsWidth-1:0]] <= wrData;
	end

	//--------------------------------------------------------------------
	// Read side
	//--------------------------------------------------------------------
	// Reset into audioClk
	always_ff @(posedge audioClk)
		rdRstSync <= {rdRstSync[0], rstN};
	assign rdRstN = rdRstSync[1];

	assign rdEmpty   = (rdGray == wrGraySync2);
	assign rdTake    = rdPop & ~rdEmpty;
	assign rdBinNext = rdBin + (adrsWidth+1)'(rdTake);

	always_ff @(posedge audioClk)
	begin
		if (!rdRstN)
		begin
			rdBin       <= '0;
			rdGray      <= '0;
			wrGraySync1 <= '0;
			wrGraySync2 <= '0;
		end
		else
		begin
			rdBin       <= rdBinNext;
			rdGray      <= toGray(rdBinNext);
			wrGraySync1 <= wrGray;
			wrGraySync2 <= wrGraySync1;
		end
	end

	// Head of queue, valid while not empty
	assign rdData = fifoMem[rdBin[adrsWidth-1:0]];

endmodule

//--- audioSynth/audioWaveRom.sv
/*
 * Audio wave ROM
 * Full sine period from a 64-entry quarter-wave table,
 * folded by quadrant and registered
 */
`timescale 1ns/1ps

module audioWaveRom
	import audioSynthPkg::*;
(
	input  logic                   audioClk,
	input  logic [7:0]             waveIndex,
	output logic [sampleWidth-1:0] wave
);

	logic [sampleWidth-1:0] quarterTable [64];
	logic [5:0]             tableAdrs;
	logic [sampleWidth-1:0] magnitude;
	logic [sampleWidth:0]   upperSum;
	logic [sampleWidth:0]   lowerDiff;

	initial
		$readmemh(sineFile, quarterTable);

	// Bit 6 runs the quarter backwards
	assign tableAdrs = waveIndex[6] ? ~waveIndex[5:0] : waveIndex[5:0];
	assign magnitude = quarterTable[tableAdrs];

	// Carry out means past full scale
	assign upperSum  = {1'b0, silenceLevel} + {1'b0, magnitude};
	assign lowerDiff = {1'b0, silenceLevel} - {1'b0, magnitude};

	// Bit 7 selects the negative half
	always_ff @(posedge audioClk)
	begin
		if (waveIndex[7])
			wave <= lowerDiff[sampleWidth] ? '0 : lowerDiff[sampleWidth-1:0];
		else
			wave <= upperSum[sampleWidth] ? '1 : upperSum[sampleWidth-1:0];
	end

endmodule

//--- audioSynth/audioToneSynth.sv
/*
 * Audio tone synthesizer
 * Takes one FIFO byte per 256-cycle PWM period and turns it into
 * the next duty, either a PCM sample or a sine note
 */
`timescale 1ns/1ps

module audioToneSynth
	import audioSynthPkg::*;
(
	input  logic      audioClk,
	input  logic      rstN,
	input  logic      pcmMode,
	input  audioByteU rdData,
	input  logic      rdEmpty,
	output logic      rdPop,
	output logic      pwm
);

	logic [1:0]             rstSync;
	logic                   audioRstN;
	logic [sampleWidth-1:0] periodCnt;
	logic                   periodEnd;
	logic [phaseWidth-1:0]  phase;
	logic [phaseWidth-1:0]  phaseNext;
	logic [phaseWidth-1:0]  baseStep;
	logic [phaseWidth-1:0]  noteStep;
	logic [7:0]             waveIndex;
	logic [sampleWidth-1:0] wave;
	logic [sampleWidth-1:0] levelDuty;
	logic [sampleWidth-1:0] duty;
	logic                   sineSel;

	//--------------------------------------------------------------------
	// Reset sync and period counter
	//--------------------------------------------------------------------
	always_ff @(posedge audioClk)
		rstSync <= {rstSync[0], rstN};
	assign audioRstN = rstSync[1];

	// Last cycle of the period
	assign periodEnd = (periodCnt == '1);
	// Pop only if a byte is waiting
	assign rdPop     = periodEnd & ~rdEmpty;

	//--------------------------------------------------------------------
	// Note step and phase
	//--------------------------------------------------------------------
	always_comb
	begin
		// Codes 12 to 15 are silent steps
		baseStep = (rdData.note.semitone < 4'd12) ? semitoneStep[rdData.note.semitone] : '0;
		// Octave 7 is the table itself
		noteStep = baseStep >> (3'd7 - rdData.note.octave);
		phaseNext = phase;
		if (!rdEmpty && !pcmMode)
		begin
			if (rdData.note.noteOn)
				phaseNext = phase + noteStep;
			else
				phaseNext = '0;
		end
	end

	// Lookup of the new phase at count 255, then held all period
	assign waveIndex = periodEnd ? phaseNext[phaseWidth-1 -: 8] : phase[phaseWidth-1 -: 8];

	audioWaveRom waveRom0 (
		.audioClk  (audioClk),
		.waveIndex (waveIndex),
		.wave      (wave)
	);

	//--------------------------------------------------------------------
	// Duty update at the period boundary
	//--------------------------------------------------------------------
	always_ff @(posedge audioClk)
	begin
		if (!audioRstN)
		begin
			periodCnt <= '0;
			phase     <= '0;
			sineSel   <= 1'b0;
			levelDuty <= silenceLevel;
		end
		else
		begin
			periodCnt <= periodCnt + 1'b1;
			if (periodEnd)
			begin
				phase <= phaseNext;
				// Empty FIFO gives silence and keeps the phase
				if (rdEmpty)
				begin
					sineSel   <= 1'b0;
					levelDuty <= silenceLevel;
				end
				else if (pcmMode)
				begin
					sineSel   <= 1'b0;
					levelDuty <= rdData.pcm;
				end
				else if (rdData.note.noteOn)
					sineSel <= 1'b1;
				else
				begin
					sineSel   <= 1'b0;
					levelDuty <= silenceLevel;
				end
			end
		end
	end

	// New duty valid from count 0
	assign duty = sineSel ? wave : levelDuty;
	assign pwm  = (periodCnt < duty);

endmodule

//--- verilog/audioTxUnit.sv
/*
 * Audio transmitter top level
 * DMA reads sample words from memory, a dual-clock FIFO moves the
 * bytes to the audio clock and the tone synthesizer drives pwm
 */
`timescale 1ns/1ps

module audioTxUnit
	import audioBusPkg::*, audioSynthPkg::*;
#(
	parameter int memAdrsWidth = 19,
	parameter int fifoDepth    = 32
)(
	input  logic                    sClk,
	input  logic                    audioClk,
	input  logic                    rstN,
	// DMA control
	input  logic                    dmaEn,
	input  logic [memAdrsWidth-1:0] dmaAdrs,
	input  logic [memAdrsWidth-1:0] dmaLen,
	output logic                    dmaBusy,
	// Memory read bus
	output logic [memAdrsWidth-1:0] memAdrs,
	output logic                    memReq,
	input  logic                    memRdy,
	input  logic                    memRdValid,
	input  logic [memDataWidth-1:0] memRdData,
	// Audio side
	input  logic                    pcmMode,
	output logic                    pwm
);

	//--------------------------------------------------------------------
	// Byte stream between the blocks
	//--------------------------------------------------------------------
	logic                   wrValid;
	logic                   wrReady;
	logic [sampleWidth-1:0] wrData;
	audioByteU              rdData;
	logic                   rdEmpty;
	logic                   rdPop;

	// Memory words to bytes, sClk domain
	audioDma #(
		.memAdrsWidth (memAdrsWidth)
	) audioDma0 (
		.sClk       (sClk),
		.rstN       (rstN),
		.dmaEn      (dmaEn),
		.dmaAdrs    (dmaAdrs),
		.dmaLen     (dmaLen),
		.dmaBusy    (dmaBusy),
		.memAdrs    (memAdrs),
		.memReq     (memReq),
		.memRdy     (memRdy),
		.memRdValid (memRdValid),
		.memRdData  (memRdData),
		.wrValid    (wrValid),
		.wrData     (wrData),
		.wrReady    (wrReady)
	);

	// Clock crossing into audioClk
	audioDualClkFifo #(
		.fifoDepth (fifoDepth)
	) audioFifo0 (
		.sClk     (sClk),
		.audioClk (audioClk),
		.rstN     (rstN),
		.wrValid  (wrValid),
		.wrData   (wrData),
		.wrReady  (wrReady),
		.rdPop    (rdPop),
		.rdData   (rdData),
		.rdEmpty  (rdEmpty)
	);

	// One sample per PWM period
	audioToneSynth audioSynth0 (
		.audioClk (audioClk),
		.rstN     (rstN),
		.pcmMode  (pcmMode),
		.rdData   (rdData),
		.rdEmpty  (rdEmpty),
		.rdPop    (rdPop),
		.pwm      (pwm)
	);

endmodule

//--- tests/audioTxUnitSva.sv
/*
 * Audio transmitter bus checks
 * Memory request, DMA busy, FIFO full and FIFO pop rules
 */
`timescale 1ns/1ps

module audioTxUnitSva #(
	parameter int memAdrsWidth = 19,
	parameter int fifoDepth    = 32
)(
	input logic                       sClk,
	input logic                       audioClk,
	input logic                       rstN,
	input logic                       dmaEn,
	input logic [memAdrsWidth-1:0]    dmaLen,
	input logic                       memReq,
	input logic                       memRdy,
	input logic                       dmaBusy,
	input logic [memAdrsWidth-1:0]    memAdrs,
	input logic                       wrValid,
	input logic                       wrReady,
	input logic [$clog2(fifoDepth):0] wrBin,
	input logic [$clog2(fifoDepth):0] rdBin,
	input logic                       rdPop
);

	// Count of failed rules
	int                         ruleErrors = 0;
	logic [memAdrsWidth-1:0]    reqsLeft;
	logic [$clog2(fifoDepth):0] fillLevel;

	// Words still to request in the current transfer
	always_ff @(posedge sClk)
	begin
		if (!rstN)
			reqsLeft <= '0;
		else if (dmaEn && !dmaBusy)
			reqsLeft <= dmaLen;
		else if (memReq && memRdy)
			reqsLeft <= reqsLeft - 1'b1;
	end

	// True occupancy, never below the synchronized view
	assign fillLevel = wrBin - rdBin;

	// Waiting request keeps its address
	assert property (@(posedge sClk) disable iff (!rstN)
		(memReq && !memRdy) |=> (memReq && $stable(memAdrs)))
	else
	begin
		$error("memAdrs or memReq changed while the request waited");
		ruleErrors++;
	end

	// Requests only inside a transfer with words left
	assert property (@(posedge sClk) disable iff (!rstN)
		memReq |-> (dmaBusy && (reqsLeft != '0)))
	else
	begin
		$error("memReq high outside a transfer or beyond its length");
		ruleErrors++;
	end

	// No push into a full FIFO
	assert property (@(posedge sClk) disable iff (!rstN)
		(wrValid && wrReady) |-> (fillLevel < fifoDepth))
	else
	begin
		$error("write accepted while the FIFO was full");
		ruleErrors++;
	end

	// Pop only with data written
	assert property (@(posedge audioClk) disable iff (!rstN)
		rdPop |-> (wrBin != rdBin))
	else
	begin
		$error("rdPop high while the FIFO was empty");
		ruleErrors++;
	end

endmodule

bind audioTxUnit audioTxUnitSva #(
	.memAdrsWidth (memAdrsWidth),
	.fifoDepth    (fifoDepth)
) sva0 (
	.sClk(sClk), .audioClk(audioClk), .rstN(rstN), .dmaEn(dmaEn), .dmaLen(dmaLen),
	.memReq(memReq), .memRdy(memRdy), .dmaBusy(dmaBusy), .memAdrs(memAdrs),
	.wrValid(wrValid), .wrReady(wrReady), .wrBin(audioFifo0.wrBin),
	.rdBin(audioFifo0.rdBin), .rdPop(rdPop)
);

//--- tests/audioTxUnitTb.sv
/*
 * Audio transmitter testbench
 * Memory model, PWM duty monitor and a reference model of the
 * duty rule, with one directed task per behavior
 */
`timescale 1ns/1ps

module audioTxUnitTb;

	localparam int memAdrsWidth = 19;
	localparam int fifoDepth    = 32;
	localparam int memWords     = 1024;
	localparam logic [7:0] silence = 8'd128;
	// Octave 7 phase steps, C up to B
	localparam logic [15:0] stepTable [12] = '{
		16'd8192,  16'd8679,  16'd9195,  16'd9742,
		16'd10321, 16'd10935, 16'd11585, 16'd12274,
		16'd13004, 16'd13777, 16'd14596, 16'd15464
	};

	logic                    sClk, audioClk, rstN;
	logic                    dmaEn, pcmMode, memRdy, memRdValid;
	logic [memAdrsWidth-1:0] dmaAdrs, dmaLen, memAdrs;
	logic [15:0]             memRdData;
	logic                    dmaBusy, memReq, pwm;

	logic [15:0]             memArray [memWords];
	logic [7:0]              sineTable [64];
	logic [31:0]             rngState;
	logic                    rdyAlways;
	logic                    pending;
	logic [memAdrsWidth-1:0] pendAdrs;
	int                      delayCnt;
	logic [memAdrsWidth-1:0] adrsLog [$];
	logic [7:0]              dutyQ [$];
	logic [7:0]              played [$];
	logic [7:0]              expected [$];
	logic [15:0]             modelPhase;
	int                      highCnt;
	bit                      inPeriod;
	bit                      sawFull;

	audioTxUnit #(
		.memAdrsWidth (memAdrsWidth),
		.fifoDepth    (fifoDepth)
	) dut0 (
		.sClk(sClk), .audioClk(audioClk), .rstN(rstN), .dmaEn(dmaEn),
		.dmaAdrs(dmaAdrs), .dmaLen(dmaLen), .dmaBusy(dmaBusy), .memAdrs(memAdrs),
		.memReq(memReq), .memRdy(memRdy), .memRdValid(memRdValid),
		.memRdData(memRdData), .pcmMode(pcmMode), .pwm(pwm)
	);

	initial
	begin
		sClk = 1'b0;
		forever #5 sClk = ~sClk;
	end

	initial
	begin
		audioClk = 1'b0;
		forever #7 audioClk = ~audioClk;
	end

	//--------------------------------------------------------------------
	// Helpers and reference model
	//--------------------------------------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// Word pattern over the full address, bytes never mid-scale
	function automatic logic [15:0] fillWord(input int a);
		logic [15:0] w;
		w = 16'(a * 40503 + 12345) ^ 16'(a >> 2);
		if (w[7:0] == 8'h80)
			w[7:0] = 8'h81;
		if (w[15:8] == 8'h80)
			w[15:8] = 8'h81;
		return w;
	endfunction

	// Quadrant fold of the quarter table
	function automatic logic [7:0] sineModel(input logic [7:0] idx);
		int mag;
		int level;
		mag = idx[6] ? sineTable[63 - idx[5:0]] : sineTable[idx[5:0]];
		level = idx[7] ? 128 - mag : 128 + mag;
		if (level > 255)
			level = 255;
		if (level < 0)
			level = 0;
		return 8'(level);
	endfunction

	// One note code, updates the model phase
	function automatic logic [7:0] toneDuty(input logic [7:0] code);
		logic [15:0] step;
		if (!code[7])
		begin
			modelPhase = '0;
			return silence;
		end
		step = (code[3:0] < 12) ? stepTable[code[3:0]] : 16'd0;
		modelPhase = modelPhase + (step >> (7 - code[6:4]));
		return sineModel(modelPhase[15:8]);
	endfunction

	task automatic abortRun(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1, "first error, run stopped");
	endtask

	//--------------------------------------------------------------------
	// Memory model, random ready and read delay
	//--------------------------------------------------------------------
	always @(posedge sClk)
	begin
		if (!rstN)
		begin
			memRdy     <= 1'b0;
			memRdValid <= 1'b0;
			pending    = 1'b0;
		end
		else
		begin
			rngState = xorshift32(rngState);
			memRdy <= rdyAlways | (rngState[1:0] != 2'b00);
			memRdValid <= 1'b0;
			if (memReq && memRdy)
			begin
				adrsLog.push_back(memAdrs);
				pending  = 1'b1;
				pendAdrs = memAdrs;
				delayCnt = 1 + (rngState[10:8] % 6);
			end
			else if (pending)
			begin
				delayCnt--;
				if (delayCnt == 0)
				begin
					memRdValid <= 1'b1;
					memRdData  <= memArray[pendAdrs[9:0]];
					pending    = 1'b0;
				end
			end
		end
	end

	// FIFO full seen
	always @(posedge sClk)
		if (rstN && dut0.wrReady === 1'b0)
			sawFull = 1'b1;

	// Bound bus and FIFO rules
	always @(posedge sClk)
		assert (dut0.sva0.ruleErrors == 0)
		else abortRun("a bus or FIFO rule assertion failed");

	// PWM monitor, high cycles per 256-cycle period
	always @(posedge audioClk)
	begin
		if (dut0.audioSynth0.audioRstN !== 1'b1)
		begin
			inPeriod = 1'b0;
			highCnt  = 0;
		end
		else
		begin
			if (dut0.audioSynth0.periodCnt == 8'd0)
			begin
				inPeriod = 1'b1;
				highCnt  = 0;
			end
			if (inPeriod)
			begin
				if (pwm)
					highCnt++;
				if (dut0.audioSynth0.periodCnt == 8'd255)
					dutyQ.push_back(8'(highCnt));
			end
		end
	end

	//--------------------------------------------------------------------
	// Transfer and playback tasks
	//--------------------------------------------------------------------
	task automatic waitDmaIdle(input int limit);
		int cnt;
		cnt = 0;
		@(negedge sClk);
		while (dmaBusy)
		begin
			cnt++;
			if (cnt > limit)
				abortRun("dmaBusy did not fall before the timeout");
			@(negedge sClk);
		end
	endtask

	task automatic startTransfer(input int adrs, input int len);
		waitDmaIdle(2000);
		@(posedge sClk);
		dmaAdrs <= memAdrsWidth'(adrs);
		dmaLen  <= memAdrsWidth'(len);
		dmaEn   <= 1'b1;
		@(posedge sClk);
		dmaEn   <= 1'b0;
	endtask

	task automatic expectPcm(input int adrs, input int len);
		expected.delete();
		for (int i = 0; i < len; i++)
		begin
			expected.push_back(memArray[adrs + i][7:0]);
			expected.push_back(memArray[adrs + i][15:8]);
		end
	endtask

	// Duties after the leading silence
	task automatic capturePlayback(input int count);
		int cnt;
		bit started;
		logic [7:0] d;
		played.delete();
		started = 1'b0;
		cnt = 0;
		while (played.size() < count)
		begin
			@(posedge audioClk);
			cnt++;
			if (cnt > (count + 16) * 256)
				abortRun("playback did not deliver all samples before the timeout");
			while (dutyQ.size() > 0 && played.size() < count)
			begin
				d = dutyQ.pop_front();
				if (started || d != silence)
				begin
					started = 1'b1;
					played.push_back(d);
				end
			end
		end
	endtask

	task automatic comparePlayback();
		foreach (expected[i])
			assert (played[i] == expected[i])
			else abortRun($sformatf("** Error: duty[%0d] expected %h got %h",
				i, expected[i], played[i]));
	endtask

	// Two silent periods in a row once the DMA is idle
	task automatic waitForSilence();
		int cnt;
		int quiet;
		waitDmaIdle(20000);
		cnt = 0;
		quiet = 0;
		while (quiet < 2)
		begin
			@(posedge audioClk);
			cnt++;
			if (cnt > 200 * 256)
				abortRun("output did not return to silence before the timeout");
			while (dutyQ.size() > 0)
				quiet = (dutyQ.pop_front() == silence) ? quiet + 1 : 0;
		end
	endtask

	task automatic checkSilentPeriods(input int count);
		int cnt;
		logic [7:0] d;
		dutyQ.delete();
		cnt = 0;
		while (dutyQ.size() < count)
		begin
			@(posedge audioClk);
			cnt++;
			if (cnt > (count + 2) * 256)
				abortRun("no PWM periods measured before the timeout");
		end
		for (int i = 0; i < count; i++)
		begin
			d = dutyQ.pop_front();
			assert (d == silence)
			else abortRun($sformatf("** Error: duty expected %h got %h", silence, d));
		end
	endtask

	//--------------------------------------------------------------------
	// Directed tests
	//--------------------------------------------------------------------
	task automatic testReset();
		@(negedge sClk);
		assert (memReq == 1'b0)
		else abortRun($sformatf("** Error: memReq expected %h got %h", 1'b0, memReq));
		assert (dmaBusy == 1'b0)
		else abortRun($sformatf("** Error: dmaBusy expected %h got %h", 1'b0, dmaBusy));
		assert (dut0.rdPop == 1'b0)
		else abortRun($sformatf("** Error: rdPop expected %h got %h", 1'b0, dut0.rdPop));
		checkSilentPeriods(3);
	endtask

	task automatic testAddressSequence();
		adrsLog.delete();
		startTransfer(10, 20);
		// The last bytes wait for the FIFO to drain
		waitDmaIdle(20000);
		assert (adrsLog.size() == 20)
		else abortRun($sformatf("** Error: request count expected %h got %h",
			20, adrsLog.size()));
		foreach (adrsLog[i])
			assert (adrsLog[i] == memAdrsWidth'(10 + i))
			else abortRun($sformatf("** Error: memAdrs expected %h got %h",
				10 + i, adrsLog[i]));
		waitForSilence();
	endtask

	task automatic testPcmPlayback();
		dutyQ.delete();
		expectPcm(100, 12);
		startTransfer(100, 12);
		capturePlayback(24);
		comparePlayback();
		waitForSilence();
	endtask

	task automatic testBackPressure();
		@(posedge sClk);
		rdyAlways <= 1'b1;
		sawFull = 1'b0;
		dutyQ.delete();
		expectPcm(200, 3 * fifoDepth / 2);
		startTransfer(200, 3 * fifoDepth / 2);
		capturePlayback(3 * fifoDepth);
		comparePlayback();
		assert (sawFull)
		else abortRun("FIFO never reported full under back-pressure");
		@(posedge sClk);
		rdyAlways <= 1'b0;
		waitForSilence();
	endtask

	task automatic testToneMode();
		logic [7:0] codes [8];
		codes = '{8'hF0, 8'hF4, 8'h99, 8'h0C, 8'hFE, 8'hE7, 8'hD3, 8'hFB};
		@(posedge sClk);
		pcmMode <= 1'b0;
		expected.delete();
		modelPhase = '0;
		for (int i = 0; i < 4; i++)
			memArray[300 + i] = {codes[2 * i + 1], codes[2 * i]};
		foreach (codes[i])
			expected.push_back(toneDuty(codes[i]));
		dutyQ.delete();
		startTransfer(300, 4);
		capturePlayback(8);
		comparePlayback();
		waitForSilence();
		@(posedge sClk);
		pcmMode <= 1'b1;
	endtask

	task automatic testUnderrun();
		dutyQ.delete();
		expectPcm(400, 6);
		startTransfer(400, 6);
		capturePlayback(12);
		comparePlayback();
		waitDmaIdle(2000);
		// Data used up, silence follows
		checkSilentPeriods(3);
		dutyQ.delete();
		expectPcm(500, 5);
		startTransfer(500, 5);
		capturePlayback(10);
		comparePlayback();
	endtask

	//--------------------------------------------------------------------
	// Main sequence
	//--------------------------------------------------------------------
	initial
	begin
		rstN       = 1'b0;
		dmaEn      = 1'b0;
		pcmMode    = 1'b1;
		memRdy     = 1'b0;
		memRdValid = 1'b0;
		memRdData  = '0;
		dmaAdrs    = '0;
		dmaLen     = '0;
		rdyAlways  = 1'b0;
		pending    = 1'b0;
		sawFull    = 1'b0;
		modelPhase = '0;
		rngState   = 32'h627683a4;
		for (int a = 0; a < memWords; a++)
			memArray[a] = fillWord(a);
		$readmemh("audioSynth/quarterSine.hex", sineTable);
		repeat (16) @(posedge sClk);
		rstN <= 1'b1;
		testReset();
		testAddressSequence();
		testPcmPlayback();
		testBackPressure();
		testToneMode();
		testUnderrun();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

//--- flist.f
common/audioBusPkg.sv
common/audioSynthPkg.sv
audioDma/audioDma.sv
audioFifo/audioDualClkFifo.sv
audioSynth/audioWaveRom.sv
audioSynth/audioToneSynth.sv
verilog/audioTxUnit.sv
tests/audioTxUnitSva.sv
tests/audioTxUnitTb.sv

//--- audioSynth/quarterSine.hex
// One column: quarter-wave sine magnitude, 127*sin((i+0.5)*pi/128), i = 0 to 63
02
05
08
0b
0e
11
14
17
1a
1d
20
23
26
29
2c
2f
32
35
38
3a
3d
40
43
45
48
4a
4d
4f
52
54
56
59
5b
5d
5f
61
63
65
67
69
6a
6c
6e
6f
71
72
73
75
76
77
78
79
7a
7b
7c
7c
7d
7d
7e
7e
7f
7f
7f
7f
